/* common/snd_bus_pkg.sv */
//====================
// sound CPU bus package
// memory map constants of the sound CPU and
// the bus cycle and registered select structs
//====================
`default_nettype none

package snd_bus_pkg;

    // fixed ROM window 0000-7FFF
    localparam logic [15:0] rom_fixed_top = 16'h7FFF;
    // banked ROM window 8000-BFFF, 16 KB per bank
    localparam logic [15:0] rom_bank_base = 16'h8000;
    localparam logic [15:0] rom_bank_top  = 16'hBFFF;

    localparam logic [3:0] ram_page_lo = 4'hC;
    localparam logic [3:0] ram_page_hi = 4'hF;
    localparam logic [3:0] qsnd_page   = 4'hD;   // DSP mailbox page

    localparam int ram_aw = 13;   // 8 KB work RAM
    localparam int rom_aw = 19;   // 512 KB program ROM

    // one CPU bus cycle, 29 bits
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  dout;
        logic        mreq_n;
        logic        rd_n;
        logic        wr_n;
        logic        m1_n;
        logic        iorq_n;
    } z80_bus_t;

    // selects registered by the decoder, 16 bits
    typedef struct packed {
        logic       rom;
        logic       ram;
        logic       qsnd_wr;   // mailbox data/address write
        logic       bank_wr;
        logic       qsnd_rd;   // status read
        logic [2:0] reg_ofs;
        logic [7:0] wdata;
    } snd_sel_t;

endpackage

`default_nettype wire

/* common/qsnd_pkg.sv */
//====================
// QSound DSP package
// DSP port struct, sample type, mailbox offsets
//====================
`default_nettype none

package qsnd_pkg;

    typedef logic signed [15:0] sample_t;

    // everything the DSP drives towards the glue, 54 bits
    typedef struct packed {
        logic        pods_n;     // parallel output strobe
        logic        pids_n;     // parallel input strobe
        logic        sadd;       // serial address
        logic        psel;       // channel select, high for right
        logic        iack;
        logic        cen_cko;
        logic [15:0] ab;
        logic [15:0] pbus_out;
        logic [15:0] serout;
    } dsp_port_t;

    // mailbox offsets inside the QSound page
    localparam logic [2:0] reg_data_hi = 3'd0;
    localparam logic [2:0] reg_data_lo = 3'd1;
    localparam logic [2:0] reg_addr    = 3'd2;   // also starts the transfer
    localparam logic [2:0] reg_bank    = 3'd3;
    localparam logic [2:0] reg_status  = 3'd7;

endpackage

`default_nettype wire

/* source/snd_addr_decode.sv */
//====================
// sound CPU address decoder
// registers chip selects per memory request,
// forms the banked ROM address and muxes read data
//====================
`timescale 1ns/1ps
`default_nettype none

module snd_addr_decode (
    input  logic                              clk48,
    input  logic                              rst,
    input  snd_bus_pkg::z80_bus_t             z80_bus,
    input  logic [7:0]                        rom_data,
    input  logic [7:0]                        ram_data,
    input  logic [7:0]                        status_byte,
    input  logic [3:0]                        bank,
    output snd_bus_pkg::snd_sel_t             snd_sel,
    output logic [snd_bus_pkg::rom_aw-1:0]    rom_addr,
    output logic                              rom_cs,
    output logic [snd_bus_pkg::ram_aw-1:0]    ram_addr,
    output logic                              ram_we,
    output logic [7:0]                        cpu_din
);

    localparam int rw = snd_bus_pkg::rom_aw;
    localparam logic [rw-1:0] bank_base = rw'(snd_bus_pkg::rom_bank_base);

    logic [3:0]            page;
    logic                  in_fixed, in_bank, in_ram, in_qsnd;
    snd_bus_pkg::snd_sel_t sel_d;

    always_comb begin
        page     = z80_bus.addr[15:12];
        in_fixed = z80_bus.addr <= snd_bus_pkg::rom_fixed_top;
        in_bank  = z80_bus.addr >= snd_bus_pkg::rom_bank_base &&
                   z80_bus.addr <= snd_bus_pkg::rom_bank_top;
        in_ram   = page == snd_bus_pkg::ram_page_lo || page == snd_bus_pkg::ram_page_hi;
        in_qsnd  = page == snd_bus_pkg::qsnd_page;
        sel_d    = '0;
        if (!z80_bus.mreq_n) begin
            sel_d.rom     = in_fixed | in_bank;
            sel_d.ram     = in_ram;
            sel_d.qsnd_wr = in_qsnd && !z80_bus.wr_n && z80_bus.addr[2:0] <= qsnd_pkg::reg_addr;
            sel_d.bank_wr = in_qsnd && !z80_bus.wr_n && z80_bus.addr[2:0] == qsnd_pkg::reg_bank;
            sel_d.qsnd_rd = in_qsnd && !z80_bus.rd_n &&
                            z80_bus.addr[2:0] == qsnd_pkg::reg_status;
        end
        sel_d.reg_ofs = z80_bus.addr[2:0];
        sel_d.wdata   = z80_bus.dout;
    end

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            snd_sel <= '0;
            ram_we  <= 1'b0;
        end else begin
            snd_sel <= sel_d;
            ram_we  <= sel_d.ram & ~z80_bus.wr_n;
        end
    end

    // addresses only move while a request is active
    always_ff @(posedge clk48) begin
        if (!z80_bus.mreq_n) begin
            rom_addr <= in_bank ? {{(rw-18){1'b0}}, bank, z80_bus.addr[13:0]} + bank_base
                                : {{(rw-15){1'b0}}, z80_bus.addr[14:0]};
            ram_addr <= z80_bus.addr[snd_bus_pkg::ram_aw-1:0];
        end
    end

    assign rom_cs  = snd_sel.rom;
    assign cpu_din = snd_sel.rom     ? rom_data    :
                     snd_sel.ram     ? ram_data    :
                     snd_sel.qsnd_rd ? status_byte : 8'hFF;   // open bus

    a_one_sel: assert property (@(posedge clk48) disable iff (rst)
        $onehot0({snd_sel.rom, snd_sel.ram, snd_sel.qsnd_wr, snd_sel.bank_wr, snd_sel.qsnd_rd}))
        else $error("decode: more than one select active");

endmodule

`default_nettype wire

/* source/z80_irq_timer.sv */
//====================
// sound CPU interrupt timer
// periodic int_n counted in cen8 ticks,
// released by the acknowledge cycle
//====================
`timescale 1ns/1ps
`default_nettype none

module z80_irq_timer #(
    parameter int IRQ_PERIOD = 32000
) (
    input  logic                  clk48,
    input  logic                  rst,
    input  logic                  cen8,
    input  snd_bus_pkg::z80_bus_t z80_bus,
    output logic                  int_n
);

    localparam int cw = $clog2(IRQ_PERIOD + 1);
    localparam logic [cw-1:0] term = cw'(IRQ_PERIOD - 1);

    logic [cw-1:0] cnt;
    logic          ack;

    assign ack = !z80_bus.m1_n && !z80_bus.iorq_n;   // interrupt acknowledge

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            cnt   <= '0;
            int_n <= 1'b1;
        end else if (cen8) begin
            cnt <= cnt == term ? '0 : cnt + 1'b1;
            if (ack)
                int_n <= 1'b1;
            else if (cnt == term)
                int_n <= 1'b0;
        end
    end

    a_int_on_tick: assert property (@(posedge clk48) disable iff (rst)
        $fell(int_n) |-> $past(cen8)) else $error("int_n fell off a cen8 tick");

endmodule

`default_nettype wire

/* qsnd/qsnd_host_regs.sv */
//====================
// QSound host mailbox
// data word and address byte from the sound CPU,
// bank register, DSP reset and the two-step DSP
// interrupt read of the parallel port
//====================
`timescale 1ns/1ps
`default_nettype none

module qsnd_host_regs (
    input  logic                  clk48,
    input  logic                  rst,
    input  snd_bus_pkg::snd_sel_t snd_sel,
    input  qsnd_pkg::dsp_port_t   dsp,
    output logic [3:0]            bank,
    output logic [7:0]            status_byte,
    output logic [15:0]           pbus_in,
    output logic                  dsp_irq,
    output logic                  dsp_rdy_n,
    output logic                  dsp_rst
);

    logic [15:0] data_word;
    logic [7:0]  addr_byte;
    logic [1:0]  step;          // 11 address phase, then data
    logic        last_pids_n;
    logic        pids_rise;
    logic        addr_wr;

    assign addr_wr   = snd_sel.qsnd_wr && snd_sel.reg_ofs == qsnd_pkg::reg_addr;
    assign pids_rise = dsp.pids_n && !last_pids_n;

    assign dsp_rdy_n   = ~(dsp_irq | dsp.iack);
    assign status_byte = {dsp_rdy_n, 3'b111, bank};

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            bank        <= 4'd0;
            dsp_rst     <= 1'b1;
            dsp_irq     <= 1'b0;
            step        <= 2'b00;
            last_pids_n <= 1'b1;
        end else begin
            last_pids_n <= dsp.pids_n;
            if (snd_sel.bank_wr) begin
                bank    <= snd_sel.wdata[3:0];
                dsp_rst <= ~snd_sel.wdata[7];   // bit 7 lets the DSP run
            end
            if (addr_wr) begin
                dsp_irq <= 1'b1;
                step    <= 2'b11;
            end else if (pids_rise) begin
                // DSP took one word
                dsp_irq <= 1'b0;
                step    <= step >> 1;
            end
        end
    end

    always_ff @(posedge clk48) begin
        if (snd_sel.qsnd_wr) begin
            case (snd_sel.reg_ofs)
                qsnd_pkg::reg_data_hi: data_word[15:8] <= snd_sel.wdata;
                qsnd_pkg::reg_data_lo: data_word[7:0]  <= snd_sel.wdata;
                qsnd_pkg::reg_addr:    addr_byte       <= snd_sel.wdata;
                default: ;
            endcase
        end
        pbus_in <= step[1] ? {8'h00, addr_byte} : data_word;
    end

    a_irq_step: assert property (@(posedge clk48) disable iff (rst)
        dsp_irq |-> step == 2'b11) else $error("dsp_irq high past the address step");

endmodule

`default_nettype wire

/* qsnd/qsnd_dsp_capture.sv */
//====================
// QSound DSP output capture
// sample ROM address from the parallel port and
// left/right words from the serial output
//====================
`timescale 1ns/1ps
`default_nettype none

module qsnd_dsp_capture #(
    parameter int GAIN_SHIFT = 0
) (
    input  logic                clk48,
    input  logic                rst,
    input  qsnd_pkg::dsp_port_t dsp,
    output logic [22:0]         qsnd_addr,
    output qsnd_pkg::sample_t   frame_left,
    output qsnd_pkg::sample_t   frame_right,
    output logic                frame_done
);

    logic              last_pods_n, last_sadd, last_psel;
    logic              pods_rise, sadd_fall, psel_rise;
    qsnd_pkg::sample_t hold_left, hold_right;

    assign pods_rise = dsp.pods_n && !last_pods_n;
    assign sadd_fall = !dsp.sadd && last_sadd;
    assign psel_rise = dsp.psel && !last_psel;

    // reset values chosen so no edge shows up right after reset
    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            last_pods_n <= 1'b1;
            last_sadd   <= 1'b0;
            last_psel   <= 1'b1;
            qsnd_addr   <= 23'd0;
            frame_done  <= 1'b0;
        end else begin
            last_pods_n <= dsp.pods_n;
            last_sadd   <= dsp.sadd;
            last_psel   <= dsp.psel;
            frame_done  <= psel_rise;
            if (pods_rise)
                qsnd_addr[15:0] <= dsp.pbus_out;
            if (dsp.ab[15] && dsp.cen_cko)
                qsnd_addr[22:16] <= dsp.ab[6:0];   // upper ROM bits
        end
    end

    always_ff @(posedge clk48) begin
        if (sadd_fall) begin
            if (!dsp.psel)
                hold_left  <= qsnd_pkg::sample_t'(dsp.serout << GAIN_SHIFT);
            else
                hold_right <= qsnd_pkg::sample_t'(dsp.serout << GAIN_SHIFT);
        end
        if (psel_rise) begin
            frame_left  <= hold_left;
            frame_right <= hold_right;
        end
    end

endmodule

`default_nettype wire

/* qsnd/qsnd_rate_gate.sv */
//====================
// QSound sample-rate gate
// sleeps the DSP after each frame and publishes
// one stereo sample every SAMPLE_PERIOD cycles
//====================
`timescale 1ns/1ps
`default_nettype none

module qsnd_rate_gate #(
    parameter int SAMPLE_PERIOD = 2000
) (
    input  logic              clk48,
    input  logic              rst,
    input  logic              qsnd_ok,
    input  qsnd_pkg::sample_t frame_left,
    input  qsnd_pkg::sample_t frame_right,
    input  logic              frame_done,
    output logic              qsnd_cen,
    output qsnd_pkg::sample_t left,
    output qsnd_pkg::sample_t right,
    output logic              sample
);

    localparam int cw = $clog2(SAMPLE_PERIOD + 1);
    localparam logic [cw-1:0] term = cw'(SAMPLE_PERIOD - 1);

    logic [cw-1:0] cnt;
    logic          sleep;

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            cnt      <= '0;
            sleep    <= 1'b0;
            qsnd_cen <= 1'b1;
            sample   <= 1'b0;
            left     <= '0;
            right    <= '0;
        end else begin
            qsnd_cen <= ~sleep & qsnd_ok;   // DSP also stalls on slow ROM
            if (cnt == term) begin
                cnt    <= '0;
                sleep  <= 1'b0;   // wake for the next period
                sample <= 1'b1;
                left   <= frame_left;
                right  <= frame_right;
            end else begin
                cnt    <= cnt + 1'b1;
                sample <= 1'b0;
                if (frame_done)
                    sleep <= 1'b1;
            end
        end
    end

    a_sample_pulse: assert property (@(posedge clk48) disable iff (rst)
        sample |=> !sample) else $error("sample held for two cycles");

endmodule

`default_nettype wire

/* source/cps15_snd_glue.sv */
//====================
// CPS-1.5 sound glue, top level
// sound CPU decode and interrupt, QSound mailbox,
// DSP capture and sample-rate gate
//====================
`timescale 1ns/1ps
`default_nettype none

module cps15_snd_glue #(
    parameter int IRQ_PERIOD    = 32000,
    parameter int SAMPLE_PERIOD = 2000,
    parameter int GAIN_SHIFT    = 0
) (
    input  logic                              clk48,
    input  logic                              rst,
    input  logic                              cen8,
    input  snd_bus_pkg::z80_bus_t             z80_bus,
    input  logic [7:0]                        rom_data,
    input  logic [7:0]                        ram_data,
    input  qsnd_pkg::dsp_port_t               dsp,
    input  logic                              qsnd_ok,
    output logic [7:0]                        cpu_din,
    output logic [snd_bus_pkg::rom_aw-1:0]    rom_addr,
    output logic                              rom_cs,
    output logic [snd_bus_pkg::ram_aw-1:0]    ram_addr,
    output logic                              ram_we,
    output logic                              int_n,
    output logic [15:0]                       pbus_in,
    output logic                              dsp_irq,
    output logic                              dsp_rdy_n,
    output logic                              dsp_rst,
    output logic [22:0]                       qsnd_addr,
    output logic                              qsnd_cen,
    output qsnd_pkg::sample_t                 left,
    output qsnd_pkg::sample_t                 right,
    output logic                              sample
);

    snd_bus_pkg::snd_sel_t snd_sel;
    logic [7:0]            status_byte;
    logic [3:0]            bank;
    qsnd_pkg::sample_t     frame_left, frame_right;
    logic                  frame_done;

    snd_addr_decode u_decode (
        .clk48, .rst, .z80_bus, .rom_data, .ram_data, .status_byte, .bank,
        .snd_sel, .rom_addr, .rom_cs, .ram_addr, .ram_we, .cpu_din
    );

    z80_irq_timer #(.IRQ_PERIOD(IRQ_PERIOD)) u_irq (
        .clk48, .rst, .cen8, .z80_bus, .int_n
    );

    qsnd_host_regs u_host (
        .clk48, .rst, .snd_sel, .dsp,
        .bank, .status_byte, .pbus_in, .dsp_irq, .dsp_rdy_n, .dsp_rst
    );

    qsnd_dsp_capture #(.GAIN_SHIFT(GAIN_SHIFT)) u_capture (
        .clk48, .rst, .dsp, .qsnd_addr, .frame_left, .frame_right, .frame_done
    );

    qsnd_rate_gate #(.SAMPLE_PERIOD(SAMPLE_PERIOD)) u_gate (
        .clk48, .rst, .qsnd_ok, .frame_left, .frame_right, .frame_done,
        .qsnd_cen, .left, .right, .sample
    );

endmodule

`default_nettype wire

/* verification/tb_cps15_snd_glue.sv */
//====================
// testbench for the CPS-1.5 sound glue
// table of CPU bus cycles and DSP strobes,
// applied in a loop with expected values
//====================
`timescale 1ns/1ps
`default_nettype none

module tb_cps15_snd_glue;

    localparam int IRQ_PERIOD    = 40;
    localparam int SAMPLE_PERIOD = 64;
    localparam int MAX_ROWS      = 32;

    // row operations
    localparam int OP_WRITE     = 0;
    localparam int OP_READ      = 1;
    localparam int OP_READ_ROMA = 2;
    localparam int OP_READ_RAMA = 3;
    localparam int OP_WRITE_WE  = 4;
    localparam int OP_CHECK     = 5;
    localparam int OP_PIDS      = 6;
    localparam int OP_PODS      = 7;
    localparam int OP_FRAME     = 8;
    localparam int OP_IRQ       = 9;

    // signal ids for OP_CHECK
    localparam int SIG_DSP_RST = 0;
    localparam int SIG_DSP_IRQ = 1;
    localparam int SIG_PBUS    = 2;
    localparam int SIG_INT_N   = 3;
    localparam int SIG_SAMPLE  = 4;
    localparam int SIG_CEN     = 5;
    localparam int SIG_RDY_N   = 6;

    localparam logic [7:0] rom_byte = 8'hA5;
    localparam logic [7:0] ram_byte = 8'h3C;

    logic                  clk48;
    logic                  rst;
    logic                  cen8;
    snd_bus_pkg::z80_bus_t z80_bus;
    logic [7:0]            rom_data;
    logic [7:0]            ram_data;
    qsnd_pkg::dsp_port_t   dsp;
    logic                  qsnd_ok;
    logic [7:0]            cpu_din;
    logic [18:0]           rom_addr;
    logic                  rom_cs;
    logic [12:0]           ram_addr;
    logic                  ram_we;
    logic                  int_n;
    logic [15:0]           pbus_in;
    logic                  dsp_irq;
    logic                  dsp_rdy_n;
    logic                  dsp_rst;
    logic [22:0]           qsnd_addr;
    logic                  qsnd_cen;
    qsnd_pkg::sample_t     left;
    qsnd_pkg::sample_t     right;
    logic                  sample;

    int          row_op   [MAX_ROWS];
    logic [15:0] row_arg  [MAX_ROWS];
    logic [7:0]  row_data [MAX_ROWS];
    logic [31:0] row_exp  [MAX_ROWS];
    int          nrows;
    int          errors;
    int          row_fail;
    int          cyc;
    int          limit;
    int          phase;
    int          tick_cnt;
    int          fall_tick;
    integer      seed;

    cps15_snd_glue #(
        .IRQ_PERIOD(IRQ_PERIOD), .SAMPLE_PERIOD(SAMPLE_PERIOD), .GAIN_SHIFT(0)
    ) DUT (
        .clk48, .rst, .cen8, .z80_bus, .rom_data, .ram_data, .dsp, .qsnd_ok,
        .cpu_din, .rom_addr, .rom_cs, .ram_addr, .ram_we, .int_n, .pbus_in,
        .dsp_irq, .dsp_rdy_n, .dsp_rst, .qsnd_addr, .qsnd_cen, .left, .right, .sample
    );

    initial clk48 = 1'b0;
    always #10 clk48 = ~clk48;

    // cen8 every 6th cycle, ticks counted from reset release
    always @(negedge clk48) begin
        if (!rst && !int_n && fall_tick < 0)
            fall_tick = tick_cnt;
        phase = (phase == 5) ? 0 : phase + 1;
        cen8  = (phase == 0);
        if (!rst && cen8)
            tick_cnt = tick_cnt + 1;
    end

    // watchdog
    always @(posedge clk48) begin
        cyc = cyc + 1;
        if (limit > 0 && cyc > limit) begin
            $display("Timeout: run exceeded %0d cycles", limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic add_row(input int op, input logic [15:0] arg, input logic [7:0] data,
                           input logic [31:0] exp);
        row_op[nrows]   = op;
        row_arg[nrows]  = arg;
        row_data[nrows] = data;
        row_exp[nrows]  = exp;
        nrows = nrows + 1;
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            row_fail = 1;
        end
    endtask

    // one memory cycle, sampled on the negedge after the select registers
    task automatic bus_cycle(input logic wr, input logic [15:0] addr, input logic [7:0] data);
        z80_bus.addr   = addr;
        z80_bus.dout   = data;
        z80_bus.mreq_n = 1'b0;
        z80_bus.rd_n   = wr;
        z80_bus.wr_n   = ~wr;
        @(negedge clk48);
        z80_bus.mreq_n = 1'b1;
        z80_bus.rd_n   = 1'b1;
        z80_bus.wr_n   = 1'b1;
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk48);
    endtask

    task automatic wait_sample();
        do @(negedge clk48); while (sample !== 1'b1);
    endtask

    task automatic serial_word(input logic psel, input logic [15:0] w);
        dsp.psel   = psel;
        dsp.serout = w;
        dsp.sadd   = 1'b1;
        idle(1);
        dsp.sadd   = 1'b0;
        idle(2);
    endtask

    task automatic frame_test();
        logic [15:0] wl;
        logic [15:0] wr;
        int          n;
        wl = 16'($random(seed));
        wr = 16'($random(seed));
        wait_sample();
        serial_word(1'b0, wl);
        serial_word(1'b1, wr);
        dsp.psel = 1'b0;
        idle(2);
        dsp.psel = 1'b1;   // frame boundary
        idle(4);
        check_val("qsnd_cen", qsnd_cen, 0);
        wait_sample();
        check_val("left", $unsigned(left), wl);
        check_val("right", $unsigned(right), wr);
        idle(1);
        check_val("qsnd_cen", qsnd_cen, 1);
        n = 1;
        while (sample !== 1'b1) begin
            @(negedge clk48);
            n = n + 1;
        end
        check_val("sample period", n, SAMPLE_PERIOD);
    endtask

    task automatic irq_test();
        logic ticked;
        while (fall_tick < 0)
            @(negedge clk48);
        if (fall_tick > IRQ_PERIOD) begin
            $display("int_n fell after %0d cen8 ticks, later than allowed", fall_tick);
            row_fail = 1;
        end
        check_val("int_n", int_n, 0);
        z80_bus.m1_n   = 1'b0;
        z80_bus.iorq_n = 1'b0;
        do begin
            @(posedge clk48);
            ticked = cen8;
            @(negedge clk48);
        end while (!ticked);
        z80_bus.m1_n   = 1'b1;
        z80_bus.iorq_n = 1'b1;
        check_val("int_n", int_n, 1);
    endtask

    task automatic apply_row(input int i);
        logic [31:0] got;
        case (row_op[i])
            OP_WRITE: begin
                bus_cycle(1'b1, row_arg[i], row_data[i]);
                idle(1);
            end
            OP_READ: begin
                bus_cycle(1'b0, row_arg[i], 8'h00);
                check_val("cpu_din", cpu_din, row_exp[i]);
            end
            OP_READ_ROMA: begin
                bus_cycle(1'b0, row_arg[i], 8'h00);
                check_val("rom_addr", rom_addr, row_exp[i]);
                check_val("rom_cs", rom_cs, 1);
                check_val("cpu_din", cpu_din, rom_byte);
            end
            OP_READ_RAMA: begin
                bus_cycle(1'b0, row_arg[i], 8'h00);
                check_val("ram_addr", ram_addr, row_exp[i]);
                check_val("rom_cs", rom_cs, 0);
                check_val("cpu_din", cpu_din, ram_byte);
            end
            OP_WRITE_WE: begin
                bus_cycle(1'b1, row_arg[i], row_data[i]);
                check_val("ram_we", ram_we, row_exp[i]);
            end
            OP_CHECK: begin
                case (row_arg[i])
                    SIG_DSP_RST: check_val("dsp_rst", dsp_rst, row_exp[i]);
                    SIG_DSP_IRQ: check_val("dsp_irq", dsp_irq, row_exp[i]);
                    SIG_PBUS:    check_val("pbus_in", pbus_in, row_exp[i]);
                    SIG_INT_N:   check_val("int_n", int_n, row_exp[i]);
                    SIG_SAMPLE:  check_val("sample", sample, row_exp[i]);
                    SIG_RDY_N:   check_val("dsp_rdy_n", dsp_rdy_n, row_exp[i]);
                    default:     check_val("qsnd_cen", qsnd_cen, row_exp[i]);
                endcase
            end
            OP_PIDS: begin
                dsp.pids_n = 1'b0;
                idle(1);
                dsp.pids_n = 1'b1;   // word taken on this rise
                idle(3);
            end
            OP_PODS: begin
                dsp.pbus_out = row_arg[i];
                dsp.pods_n   = 1'b0;
                idle(1);
                dsp.pods_n   = 1'b1;
                idle(2);
                got = qsnd_addr[15:0];
                check_val("qsnd_addr[15:0]", got, row_exp[i]);
            end
            OP_FRAME: frame_test();
            default:  irq_test();
        endcase
    endtask

    initial begin
        seed      = 32'h88348ef2;
        rst       = 1'b1;
        cen8      = 1'b0;
        phase     = 0;
        tick_cnt  = 0;
        fall_tick = -1;
        cyc       = 0;
        limit     = 0;
        errors    = 0;
        nrows     = 0;
        z80_bus   = '0;
        z80_bus.mreq_n = 1'b1;
        z80_bus.rd_n   = 1'b1;
        z80_bus.wr_n   = 1'b1;
        z80_bus.m1_n   = 1'b1;
        z80_bus.iorq_n = 1'b1;
        rom_data  = rom_byte;
        ram_data  = ram_byte;
        dsp       = '0;
        dsp.pods_n = 1'b1;
        dsp.pids_n = 1'b1;
        qsnd_ok   = 1'b1;

        // reset state; status is {rdy_n, 111, bank}
        add_row(OP_CHECK, SIG_INT_N, 0, 1);
        add_row(OP_CHECK, SIG_DSP_RST, 0, 1);
        add_row(OP_CHECK, SIG_DSP_IRQ, 0, 0);
        add_row(OP_CHECK, SIG_RDY_N, 0, 1);
        add_row(OP_CHECK, SIG_SAMPLE, 0, 0);
        add_row(OP_CHECK, SIG_CEN, 0, 1);
        add_row(OP_READ, 16'hD007, 0, 8'hF0);
        // memory decode
        add_row(OP_READ_ROMA, 16'h1234, 0, 19'h01234);
        add_row(OP_READ_RAMA, 16'hC010, 0, 13'h0010);
        add_row(OP_WRITE_WE, 16'hF003, 8'h77, 1);
        add_row(OP_READ, 16'hE000, 0, 8'hFF);
        // bank 5 and DSP run bit
        add_row(OP_WRITE, 16'hD003, 8'h85, 0);
        add_row(OP_CHECK, SIG_DSP_RST, 0, 0);
        add_row(OP_READ, 16'hD007, 0, 8'hF5);
        add_row(OP_READ_ROMA, 16'h8123, 0, 5 * 32'h4000 + 32'h8000 + 32'h0123);
        // mailbox
        add_row(OP_WRITE, 16'hD000, 8'h12, 0);
        add_row(OP_WRITE, 16'hD001, 8'h34, 0);
        add_row(OP_WRITE, 16'hD002, 8'h56, 0);
        add_row(OP_CHECK, SIG_DSP_IRQ, 0, 1);
        add_row(OP_CHECK, SIG_RDY_N, 0, 0);
        add_row(OP_READ, 16'hD007, 0, 8'h75);
        add_row(OP_CHECK, SIG_PBUS, 0, 16'h0056);
        add_row(OP_PIDS, 0, 0, 0);
        add_row(OP_CHECK, SIG_DSP_IRQ, 0, 0);
        add_row(OP_CHECK, SIG_RDY_N, 0, 1);
        add_row(OP_CHECK, SIG_PBUS, 0, 16'h1234);
        // sample path, ROM address, interrupt
        add_row(OP_FRAME, 0, 0, 0);
        add_row(OP_PODS, 16'hBEEF, 0, 16'hBEEF);
        add_row(OP_IRQ, 0, 0, 0);

        limit = nrows * 200 + 4 * SAMPLE_PERIOD;

        repeat (8) @(negedge clk48);
        rst = 1'b0;
        @(negedge clk48);

        for (int i = 0; i < nrows; i++) begin
            row_fail = 0;
            apply_row(i);
            if (row_fail != 0) begin
                errors = errors + 1;
                $display("test %0d (op %0d): failed", i, row_op[i]);
            end else begin
                $display("test %0d (op %0d): ok", i, row_op[i]);
            end
        end

        $display("tests run %0d, passed %0d, failed %0d", nrows, nrows - errors, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
common/snd_bus_pkg.sv
common/qsnd_pkg.sv
source/snd_addr_decode.sv
source/z80_irq_timer.sv
qsnd/qsnd_host_regs.sv
qsnd/qsnd_dsp_capture.sv
qsnd/qsnd_rate_gate.sv
source/cps15_snd_glue.sv
verification/tb_cps15_snd_glue.sv

/* Makefile */
# Verilator build and run of the sound glue testbench

VERILATOR ?= verilator
TOP       ?= tb_cps15_snd_glue
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "^STATUS: PASS$$" $(LOG); then \
		exit 0; \
	else \
		echo "simulation did not pass (exit $$status)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
